//--- dct8.f
+incdir+include
logic/dct_math_pkg.sv
logic/dct_sched_pkg.sv
logic/pingpong_buffer.sv
logic/dct_input_stage.sv
logic/dct_even_stage.sv
logic/dct_rotate_stage.sv
logic/dct_output_stage.sv
logic/dct8_top.sv
sim/tb_dct8.sv

//--- logic/dct8_top.sv
// 8-point DCT top level
`timescale 1ns/1ps

module dct8_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    output logic                    ready,
    output logic                    done,
    output logic                    in_re,
    output dct_sched_pkg::index_t   in_addr,
    input  dct_math_pkg::sample_t   in_rdata,
    output logic                    out_we,
    output dct_sched_pkg::index_t   out_addr,
    output dct_math_pkg::sample_t   out_wdata
);

    dct_sched_pkg::buf_wr_t st0_wr;
    dct_sched_pkg::buf_wr_t st1_wr;
    dct_sched_pkg::buf_wr_t st2_wr;
    dct_sched_pkg::buf_rd_t st1_rd;
    dct_sched_pkg::buf_rd_t st2_rd;
    dct_sched_pkg::buf_rd_t st3_rd;
    dct_math_pkg::sample_t  buf0_data;
    dct_math_pkg::sample_t  buf1_data;
    dct_math_pkg::sample_t  buf2_data;

    dct_input_stage u_input_stage (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .ready    (ready),
        .in_re    (in_re),
        .in_addr  (in_addr),
        .in_rdata (in_rdata),
        .wr       (st0_wr)
    );

    pingpong_buffer u_buffer0 (
        .clk     (clk),
        .reset   (reset),
        .wr      (st0_wr),
        .rd      (st1_rd),
        .rd_data (buf0_data)
    );

    dct_even_stage u_even_stage (
        .clk         (clk),
        .reset       (reset),
        .block_ready (st0_wr.en && st0_wr.last),
        .rd          (st1_rd),
        .rd_data     (buf0_data),
        .wr          (st1_wr)
    );

    pingpong_buffer u_buffer1 (
        .clk     (clk),
        .reset   (reset),
        .wr      (st1_wr),
        .rd      (st2_rd),
        .rd_data (buf1_data)
    );

    dct_rotate_stage u_rotate_stage (
        .clk         (clk),
        .reset       (reset),
        .block_ready (st1_wr.en && st1_wr.last),
        .rd          (st2_rd),
        .rd_data     (buf1_data),
        .wr          (st2_wr)
    );

    pingpong_buffer u_buffer2 (
        .clk     (clk),
        .reset   (reset),
        .wr      (st2_wr),
        .rd      (st3_rd),
        .rd_data (buf2_data)
    );

    dct_output_stage u_output_stage (
        .clk         (clk),
        .reset       (reset),
        .block_ready (st2_wr.en && st2_wr.last),
        .rd          (st3_rd),
        .rd_data     (buf2_data),
        .out_we      (out_we),
        .out_addr    (out_addr),
        .out_wdata   (out_wdata),
        .done        (done)
    );

endmodule

//--- logic/dct_even_stage.sv
// DCT stage 1, even butterflies
`timescale 1ns/1ps

module dct_even_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    block_ready,
    output dct_sched_pkg::buf_rd_t  rd,
    input  dct_math_pkg::sample_t   rd_data,
    output dct_sched_pkg::buf_wr_t  wr
);

    logic                   seq_en;
    dct_sched_pkg::index_t  step;
    dct_sched_pkg::buf_rd_t tag1;
    dct_sched_pkg::buf_rd_t tag2;
    dct_math_pkg::sample_t  cur;
    dct_math_pkg::sample_t  prev;

    always_ff @(posedge clk) begin
        if (reset) begin
            seq_en <= 1'b0;
            step   <= '0;
        end else if (block_ready) begin
            seq_en <= 1'b1;
            step   <= '0;
        end else if (seq_en) begin
            seq_en <= step != 3'd7;
            step   <= step + 1'b1;
        end
    end

    assign rd = '{en: seq_en, addr: dct_sched_pkg::EVEN_ORDER[step]};

    always_ff @(posedge clk) begin
        cur  <= rd_data;
        prev <= cur;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tag1    <= '0;
            tag2    <= '0;
            wr.en   <= 1'b0;
            wr.last <= 1'b0;
        end else begin
            tag1    <= rd;
            tag2    <= tag1;
            wr.en   <= tag2.en;
            wr.last <= tag2.en && tag2.addr == 3'd7;
            wr.addr <= tag2.addr;
            if (!tag2.addr[2]) begin
                wr.data <= tag2.addr[1] ? prev - cur : cur + rd_data;
            end else begin
                // odd half passes through
                wr.data <= cur;
            end
        end
    end

endmodule

//--- logic/dct_input_stage.sv
// DCT stage 0, outer butterflies
`timescale 1ns/1ps

module dct_input_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    output logic                    ready,
    output logic                    in_re,
    output dct_sched_pkg::index_t   in_addr,
    input  dct_math_pkg::sample_t   in_rdata,
    output dct_sched_pkg::buf_wr_t  wr
);

    logic                   seq_en;
    dct_sched_pkg::index_t  step;
    dct_sched_pkg::buf_rd_t tag1;
    dct_sched_pkg::buf_rd_t tag2;
    dct_math_pkg::sample_t  cur;
    dct_math_pkg::sample_t  prev;

    always_ff @(posedge clk) begin
        if (reset) begin
            seq_en <= 1'b0;
            step   <= '0;
        end else if (ready) begin
            seq_en <= start;
            step   <= '0;
        end else begin
            step <= step + 1'b1;
        end
    end

    // ready again on the eighth read
    assign ready   = !seq_en || step == 3'd7;
    assign in_re   = seq_en;
    assign in_addr = dct_sched_pkg::IN_ORDER[step];

    always_ff @(posedge clk) begin
        cur  <= in_rdata;
        prev <= cur;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tag1    <= '0;
            tag2    <= '0;
            wr.en   <= 1'b0;
            wr.last <= 1'b0;
        end else begin
            tag1    <= '{en: seq_en, addr: in_addr};
            tag2    <= tag1;
            wr.en   <= tag2.en;
            wr.last <= tag2.en && tag2.addr == 3'd4;
            wr.addr <= tag2.addr;
            // partner sample is next on the bus for sums, held for differences
            wr.data <= tag2.addr[2] ? prev - cur : cur + in_rdata;
        end
    end

endmodule

//--- logic/dct_math_pkg.sv
// DCT fixed-point arithmetic
package dct_math_pkg;

    localparam int SAMPLE_WIDTH = 18;
    localparam int FRAC_BITS    = 12;

    typedef logic signed [SAMPLE_WIDTH-1:0]   sample_t;
    typedef logic signed [2*SAMPLE_WIDTH-1:0] product_t;
    typedef logic signed [SAMPLE_WIDTH-1:0]   coef_t;

    // Q32 constant rounded to FRAC_BITS fraction bits
    function automatic coef_t from_q32(input logic [33:0] v);
        return coef_t'((v + (34'd1 << (31 - FRAC_BITS))) >> (32 - FRAC_BITS));
    endfunction

    // cos(i*pi/16) * sqrt(2)
    localparam coef_t R0 = from_q32(34'h16a09e668);
    localparam coef_t R1 = from_q32(34'h163150b16);
    localparam coef_t R2 = from_q32(34'h14e7ae914);
    localparam coef_t R3 = from_q32(34'h12d062ef9);
    localparam coef_t R4 = from_q32(34'h100000000);
    localparam coef_t R5 = from_q32(34'h0c9234e07);
    localparam coef_t R6 = from_q32(34'h08a8bd3df);
    localparam coef_t R7 = from_q32(34'h046a1577b);

    localparam coef_t RSQRT2  = from_q32(34'h0b504f334);
    localparam coef_t RSQRT2H = from_q32(34'h05a82799a);

    // rounded multiply, result wraps at sample width
    function automatic sample_t fix_mul(input sample_t a, input coef_t b);
        product_t p;
        p = product_t'(a) * product_t'(b);
        p = p + (product_t'(1) << (FRAC_BITS - 1));
        return sample_t'(p >>> FRAC_BITS);
    endfunction

endpackage

//--- logic/dct_output_stage.sv
// DCT stage 3, odd butterflies and sink writes
`timescale 1ns/1ps

module dct_output_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    block_ready,
    output dct_sched_pkg::buf_rd_t  rd,
    input  dct_math_pkg::sample_t   rd_data,
    output logic                    out_we,
    output dct_sched_pkg::index_t   out_addr,
    output dct_math_pkg::sample_t   out_wdata,
    output logic                    done
);

    logic                   seq_en;
    dct_sched_pkg::index_t  step;
    dct_sched_pkg::buf_rd_t tag [1:9];
    dct_math_pkg::sample_t  dly [2:7];
    dct_math_pkg::sample_t  pair_a;
    dct_math_pkg::sample_t  pair_b;
    dct_math_pkg::sample_t  sum5;
    dct_math_pkg::sample_t  diff5;
    dct_math_pkg::sample_t  prod6;
    dct_math_pkg::sample_t  y5;
    dct_math_pkg::sample_t  y3;
    dct_math_pkg::sample_t  p7;
    dct_math_pkg::sample_t  q7;
    dct_math_pkg::sample_t  y8;
    dct_math_pkg::sample_t  y9;
    dct_sched_pkg::buf_wr_t sink;

    always_ff @(posedge clk) begin
        if (reset) begin
            seq_en <= 1'b0;
            step   <= '0;
        end else if (block_ready) begin
            seq_en <= 1'b1;
            step   <= '0;
        end else if (seq_en) begin
            seq_en <= step != 3'd7;
            step   <= step + 1'b1;
        end
    end

    assign rd = '{en: seq_en, addr: dct_sched_pkg::OUT_READ_ORDER[step]};

    // ------------------------------------------------------------------------
    // odd half: c7/c5 feed y5 and p, c4/c6 feed y3 and q
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        dly[2] <= rd_data;
        for (int k = 3; k <= 7; k++) begin
            dly[k] <= dly[k-1];
        end
        if (tag[2].addr == 3'd5 || tag[2].addr == 3'd1) begin
            pair_a <= dly[2];
            pair_b <= rd_data;
        end
        sum5  <= pair_a + pair_b;
        diff5 <= pair_a - pair_b;
        prod6 <= dct_math_pkg::fix_mul(sum5, dct_math_pkg::RSQRT2);
        if (tag[5].addr == 3'd5) begin
            y5 <= diff5;
        end
        if (tag[5].addr == 3'd1) begin
            y3 <= diff5;
        end
        if (tag[6].addr == 3'd5) begin
            p7 <= prod6;
        end
        if (tag[6].addr == 3'd1) begin
            q7 <= prod6;
        end
        case (tag[7].addr)
            3'd5:    y8 <= y5;
            3'd3:    y8 <= y3;
            3'd1:    y8 <= q7 + p7;
            3'd7:    y8 <= q7 - p7;
            default: y8 <= dly[7];
        endcase
        y9 <= y8;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tag       <= '{default: '0};
            sink.en   <= 1'b0;
            sink.last <= 1'b0;
        end else begin
            tag[1] <= '{en: seq_en, addr: dct_sched_pkg::OUT_WRITE_ORDER[step]};
            for (int k = 2; k <= 9; k++) begin
                tag[k] <= tag[k-1];
            end
            sink.en   <= tag[9].en;
            sink.last <= tag[9].addr == 3'd7;
            sink.addr <= tag[9].addr;
            sink.data <= dct_math_pkg::fix_mul(y9, dct_math_pkg::RSQRT2H);
        end
    end

    assign out_we    = sink.en;
    assign out_addr  = sink.addr;
    assign out_wdata = sink.data;
    assign done      = sink.en && sink.last;

endmodule

//--- logic/dct_rotate_stage.sv
// DCT stage 2, scaled rotations
`timescale 1ns/1ps

module dct_rotate_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    block_ready,
    output dct_sched_pkg::buf_rd_t  rd,
    input  dct_math_pkg::sample_t   rd_data,
    output dct_sched_pkg::buf_wr_t  wr
);

    logic                   seq_en;
    dct_sched_pkg::index_t  step;
    dct_sched_pkg::buf_rd_t tag [1:5];
    dct_math_pkg::sample_t  d2;
    dct_math_pkg::sample_t  op0;
    dct_math_pkg::sample_t  op1;
    dct_math_pkg::coef_t    k0;
    dct_math_pkg::coef_t    k1;
    dct_math_pkg::sample_t  mul0;
    dct_math_pkg::sample_t  mul1;
    dct_math_pkg::sample_t  mul0_r;
    dct_math_pkg::sample_t  mul1_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            seq_en <= 1'b0;
            step   <= '0;
        end else if (block_ready) begin
            seq_en <= 1'b1;
            step   <= '0;
        end else if (seq_en) begin
            seq_en <= step != 3'd7;
            step   <= step + 1'b1;
        end
    end

    assign rd = '{en: seq_en, addr: dct_sched_pkg::ROT_ORDER[step]};

    // ------------------------------------------------------------------------
    // operand pairing and two-cycle multiply
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        d2 <= rd_data;
        if (!tag[2].addr[0]) begin
            op0 <= d2;
            op1 <= rd_data;
        end else begin
            // odd output uses the same pair swapped
            op0 <= op1;
            op1 <= op0;
        end
        case (tag[2].addr)
            3'd0, 3'd1: begin
                k0 <= dct_math_pkg::R4;
                k1 <= dct_math_pkg::R4;
            end
            3'd2, 3'd3: begin
                k0 <= dct_math_pkg::R6;
                k1 <= dct_math_pkg::R2;
            end
            3'd4, 3'd7: begin
                k0 <= dct_math_pkg::R3;
                k1 <= dct_math_pkg::coef_t'(-dct_math_pkg::R5);
            end
            default: begin
                k0 <= dct_math_pkg::R1;
                k1 <= dct_math_pkg::R7;
            end
        endcase
        mul0   <= dct_math_pkg::fix_mul(op0, k0);
        mul1   <= dct_math_pkg::fix_mul(op1, k1);
        mul0_r <= mul0;
        mul1_r <= mul1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tag     <= '{default: '0};
            wr.en   <= 1'b0;
            wr.last <= 1'b0;
        end else begin
            tag[1] <= '{en: seq_en, addr: dct_sched_pkg::ROT_WRITE_ORDER[step]};
            for (int k = 2; k <= 5; k++) begin
                tag[k] <= tag[k-1];
            end
            wr.en   <= tag[5].en;
            wr.last <= tag[5].en && tag[5].addr == 3'd5;
            wr.addr <= tag[5].addr;
            wr.data <= tag[5].addr[0] ? mul0_r - mul1_r : mul0_r + mul1_r;
        end
    end

endmodule

//--- logic/dct_sched_pkg.sv
// DCT schedule and buffer ports
package dct_sched_pkg;

    typedef logic [2:0] index_t;

    typedef struct packed {
        logic                  en;
        logic                  last;
        index_t                addr;
        dct_math_pkg::sample_t data;
    } buf_wr_t;

    typedef struct packed {
        logic   en;
        index_t addr;
    } buf_rd_t;

    // ------------------------------------------------------------------------
    // visit orders, one entry per sequence step
    // ------------------------------------------------------------------------
    localparam index_t [0:7] IN_ORDER       = {3'd0, 3'd7, 3'd1, 3'd6,
                                               3'd2, 3'd5, 3'd3, 3'd4};
    localparam index_t [0:7] EVEN_ORDER     = {3'd0, 3'd3, 3'd1, 3'd2,
                                               3'd4, 3'd5, 3'd6, 3'd7};
    localparam index_t [0:7] ROT_ORDER      = {3'd1, 3'd0, 3'd2, 3'd3,
                                               3'd7, 3'd4, 3'd5, 3'd6};
    // output index of each rotation read
    localparam index_t [0:7] ROT_WRITE_ORDER = {3'd0, 3'd1, 3'd2, 3'd3,
                                                3'd4, 3'd7, 3'd6, 3'd5};
    localparam index_t [0:7] OUT_READ_ORDER = {3'd0, 3'd1, 3'd2, 3'd3,
                                               3'd7, 3'd5, 3'd4, 3'd6};
    localparam index_t [0:7] OUT_WRITE_ORDER = {3'd0, 3'd4, 3'd2, 3'd6,
                                                3'd5, 3'd3, 3'd1, 3'd7};

endpackage

//--- logic/pingpong_buffer.sv
// Two-bank ping-pong buffer
`timescale 1ns/1ps

module pingpong_buffer (
    input  logic                    clk,
    input  logic                    reset,
    input  dct_sched_pkg::buf_wr_t  wr,
    input  dct_sched_pkg::buf_rd_t  rd,
    output dct_math_pkg::sample_t   rd_data
);

    dct_math_pkg::sample_t mem [16];
    logic                  wr_bank;
    logic                  rd_bank;

    // swap on the last write of a block
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_bank <= 1'b0;
            rd_bank <= 1'b0;
        end else if (wr.en && wr.last) begin
            rd_bank <= wr_bank;
            wr_bank <= ~wr_bank;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[{wr_bank, wr.addr}] <= wr.data;
        end
        if (rd.en) begin
            rd_data <= mem[{rd_bank, rd.addr}];
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the dct8 testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_dct8 \
    -f dct8.f -Mdir obj_dir -o tb_dct8 > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_dct8 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- include/dct8_model.svh
// DCT8 bit-exact model
`ifndef DCT8_MODEL_SVH
`define DCT8_MODEL_SVH

// full product, round half up at the fraction point, wrap to sample width
function automatic dct_math_pkg::sample_t round_mul(input dct_math_pkg::sample_t a,
                                                    input dct_math_pkg::coef_t b);
    longint full;
    full = longint'(a) * longint'(b);
    full = full + (longint'(1) << (dct_math_pkg::FRAC_BITS - 1));
    full = full >>> dct_math_pkg::FRAC_BITS;
    return dct_math_pkg::sample_t'(full);
endfunction

// one block of samples in, coefficients out by frequency index
function automatic void dct8_model(input dct_math_pkg::sample_t x [8],
                                   output dct_math_pkg::sample_t y [8]);
    dct_math_pkg::sample_t a [8];
    dct_math_pkg::sample_t b [8];
    dct_math_pkg::sample_t c [8];
    dct_math_pkg::sample_t v [8];
    dct_math_pkg::sample_t p;
    dct_math_pkg::sample_t q;
    dct_math_pkg::coef_t   r5n;
    r5n = dct_math_pkg::coef_t'(-dct_math_pkg::R5);
    for (int i = 0; i < 4; i++) begin
        a[i]   = x[i] + x[7-i];
        a[7-i] = x[i] - x[7-i];
    end
    b = a;
    b[0] = a[0] + a[3];
    b[1] = a[1] + a[2];
    b[2] = a[1] - a[2];
    b[3] = a[0] - a[3];
    c[0] = round_mul(b[1], dct_math_pkg::R4) + round_mul(b[0], dct_math_pkg::R4);
    c[1] = round_mul(b[0], dct_math_pkg::R4) - round_mul(b[1], dct_math_pkg::R4);
    c[2] = round_mul(b[2], dct_math_pkg::R6) + round_mul(b[3], dct_math_pkg::R2);
    c[3] = round_mul(b[3], dct_math_pkg::R6) - round_mul(b[2], dct_math_pkg::R2);
    c[4] = round_mul(b[7], dct_math_pkg::R3) + round_mul(b[4], r5n);
    c[7] = round_mul(b[4], dct_math_pkg::R3) - round_mul(b[7], r5n);
    c[6] = round_mul(b[5], dct_math_pkg::R1) + round_mul(b[6], dct_math_pkg::R7);
    c[5] = round_mul(b[6], dct_math_pkg::R1) - round_mul(b[5], dct_math_pkg::R7);
    p = round_mul(dct_math_pkg::sample_t'(c[7] + c[5]), dct_math_pkg::RSQRT2);
    q = round_mul(dct_math_pkg::sample_t'(c[4] + c[6]), dct_math_pkg::RSQRT2);
    v[0] = c[0];
    v[4] = c[1];
    v[2] = c[2];
    v[6] = c[3];
    v[5] = c[7] - c[5];
    v[3] = c[4] - c[6];
    v[1] = q + p;
    v[7] = q - p;
    for (int k = 0; k < 8; k++) begin
        y[k] = round_mul(v[k], dct_math_pkg::RSQRT2H);
    end
endfunction

`endif

//--- sim/tb_dct8.sv
// DCT8 testbench
`timescale 1ns/1ps

module tb_dct8;

    `include "dct8_model.svh"

    localparam int NUM_BLOCKS     = 9;
    localparam int NUM_RUNS       = 2 * NUM_BLOCKS;
    localparam int TIMEOUT_CYCLES = 200 + 80 * NUM_RUNS;

    // expected read and write address order per block
    localparam dct_sched_pkg::index_t IN_SEQ [8]  = '{0, 7, 1, 6, 2, 5, 3, 4};
    localparam dct_sched_pkg::index_t OUT_SEQ [8] = '{0, 4, 2, 6, 5, 3, 1, 7};

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  start;
    logic                  ready;
    logic                  done;
    logic                  in_re;
    dct_sched_pkg::index_t in_addr;
    dct_math_pkg::sample_t in_rdata;
    logic                  out_we;
    dct_sched_pkg::index_t out_addr;
    dct_math_pkg::sample_t out_wdata;

    dct_math_pkg::sample_t stim_tab [NUM_BLOCKS][8];
    dct_math_pkg::sample_t exp_tab [NUM_BLOCKS][8];
    string                 name_tab [NUM_BLOCKS];
    int                    row_of [$];

    logic [31:0]           lcg_state = 32'haae3_869a;
    int                    cycle_count = 0;
    int                    read_count = 0;
    int                    write_count = 0;
    int                    done_count = 0;
    logic                  rd_pending = 1'b0;
    int                    rd_block;
    dct_sched_pkg::index_t rd_index;
    int                    wr_block;
    int                    wr_pos;
    int                    wr_row;

    dct8_top u_dct8_top (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .ready     (ready),
        .done      (done),
        .in_re     (in_re),
        .in_addr   (in_addr),
        .in_rdata  (in_rdata),
        .out_we    (out_we),
        .out_addr  (out_addr),
        .out_wdata (out_wdata)
    );

    always #4 clk = ~clk;

    // ------------------------------------------------------------------------
    // failure reporting and compare tasks
    // ------------------------------------------------------------------------
    task automatic stop_on_failure();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_sample(input string name, input dct_math_pkg::sample_t exp_v,
                                input dct_math_pkg::sample_t act_v);
        if (exp_v !== act_v) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, exp_v, act_v);
            stop_on_failure();
        end
    endtask

    task automatic check_index(input string name, input dct_sched_pkg::index_t exp_v,
                               input dct_sched_pkg::index_t act_v);
        if (exp_v !== act_v) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, exp_v, act_v);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act_v);
        if (exp_v !== act_v) begin
            $display("CHECK FAILED %s expected %b actual %b", name, exp_v, act_v);
            stop_on_failure();
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic build_table();
        dct_math_pkg::sample_t xin [8];
        dct_math_pkg::sample_t yout [8];
        name_tab = '{"zero", "constant", "impulse_0", "impulse_7", "alternating",
                     "random_0", "random_1", "random_2", "random_3"};
        for (int i = 0; i < 8; i++) begin
            stim_tab[0][i] = '0;
            stim_tab[1][i] = 18'sd1500;
            stim_tab[2][i] = (i == 0) ? 18'sd4096 : 18'sd0;
            stim_tab[3][i] = (i == 7) ? 18'sd4096 : 18'sd0;
            stim_tab[4][i] = i[0] ? -18'sd1000 : 18'sd1000;
        end
        for (int r = 5; r < NUM_BLOCKS; r++) begin
            for (int i = 0; i < 8; i++) begin
                lcg_state = lcg_next(lcg_state);
                // 15-bit signed, so within +-2^14
                stim_tab[r][i] = dct_math_pkg::sample_t'($signed(lcg_state[30:16]));
            end
        end
        for (int r = 0; r < NUM_BLOCKS; r++) begin
            for (int i = 0; i < 8; i++) begin
                xin[i] = stim_tab[r][i];
            end
            dct8_model(xin, yout);
            for (int i = 0; i < 8; i++) begin
                exp_tab[r][i] = yout[i];
            end
        end
    endtask

    task automatic wait_for_done(input int count);
        while (done_count < count) begin
            @(negedge clk);
        end
    endtask

    // ------------------------------------------------------------------------
    // source memory and sink monitor
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        // data answers the read issued in the previous cycle
        if (rd_pending) begin
            in_rdata = stim_tab[row_of[rd_block]][rd_index];
        end
        rd_pending = 1'b0;
        if (in_re) begin
            rd_block = read_count / 8;
            if (rd_block >= row_of.size()) begin
                $display("source read with no block queued");
                stop_on_failure();
            end
            check_index($sformatf("%s in_addr step %0d", name_tab[row_of[rd_block]],
                                  read_count % 8), IN_SEQ[read_count % 8], in_addr);
            rd_index   = in_addr;
            rd_pending = 1'b1;
            read_count++;
        end
        if (out_we) begin
            wr_block = write_count / 8;
            wr_pos   = write_count % 8;
            if (wr_block >= row_of.size()) begin
                $display("sink write with no block in flight");
                stop_on_failure();
            end
            wr_row = row_of[wr_block];
            check_index($sformatf("%s out_addr step %0d", name_tab[wr_row], wr_pos),
                        OUT_SEQ[wr_pos], out_addr);
            check_sample($sformatf("%s out[%0d]", name_tab[wr_row], OUT_SEQ[wr_pos]),
                         exp_tab[wr_row][OUT_SEQ[wr_pos]], out_wdata);
            check_flag($sformatf("%s done step %0d", name_tab[wr_row], wr_pos),
                       wr_pos == 7, done);
            write_count++;
            if (done) begin
                done_count++;
            end
        end else begin
            check_flag("done without a sink write", 1'b0, done);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: done never arrived within %0d cycles", TIMEOUT_CYCLES);
            stop_on_failure();
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        int accepted;
        int tick;
        reset    = 1'b1;
        start    = 1'b0;
        in_rdata = '0;
        build_table();
        repeat (8) @(negedge clk);
        reset = 1'b0;
        check_flag("reset ready", 1'b1, ready);
        check_flag("reset done", 1'b0, done);
        check_flag("reset in_re", 1'b0, in_re);
        check_flag("reset out_we", 1'b0, out_we);

        // one block at a time with idle gaps
        for (int r = 0; r < NUM_BLOCKS; r++) begin
            row_of.push_back(r);
            repeat (3) @(negedge clk);
            check_flag($sformatf("%s ready before start", name_tab[r]), 1'b1, ready);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            wait_for_done(row_of.size());
        end

        // start held, one block accepted every 8 cycles
        repeat (4) @(negedge clk);
        for (int r = 0; r < NUM_BLOCKS; r++) begin
            row_of.push_back(r);
        end
        start    = 1'b1;
        accepted = 0;
        tick     = 0;
        while (accepted < NUM_BLOCKS) begin
            check_flag($sformatf("held start ready cycle %0d", tick), tick % 8 == 0, ready);
            if (ready) begin
                accepted++;
            end
            tick++;
            @(negedge clk);
        end
        start = 1'b0;
        wait_for_done(row_of.size());
        repeat (4) @(negedge clk);

        if (read_count != 8 * NUM_RUNS || write_count != 8 * NUM_RUNS) begin
            $display("read or write count wrong: %0d reads, %0d writes",
                     read_count, write_count);
            stop_on_failure();
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule
